//--- Makefile
VERILATOR  ?= verilator
TOP        := core_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/core_tb.sv
`default_nettype none

module core_tb;

	localparam int period       = 40;
	localparam int prog_words   = 64;
	localparam int fill_words   = 6;
	localparam int fill_instrs  = 1280; // 256 passes of the five-word fill loop
	localparam int rand_instrs  = 400;
	localparam int stall_budget = 200;
	localparam int timeout_cycles = fill_words + prog_words + fill_instrs + rand_instrs
		+ stall_budget + 20;

	logic        clk;
	logic        reset;
	logic        run;
	logic        load_en;
	logic [7:0]  load_addr;
	logic [31:0] load_data;
	logic        retire;
	logic [31:0] retire_pc;
	logic        wb_en;
	logic [3:0]  wb_reg;
	logic [31:0] wb_data;

	// Reference model state
	logic [31:0] m_imem [256];
	logic [31:0] m_dmem [256];
	logic [31:0] m_regs [16];
	logic [31:0] m_pc;
	logic        m_z;
	logic        m_c;
	logic        m_s;
	logic        m_o;

	logic [31:0] prog [prog_words];
	int          committed;
	int          stalls_used;

	core_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.run       (run),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.retire    (retire),
		.retire_pc (retire_pc),
		.wb_en     (wb_en),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "stopping at first error");
	endtask

	initial begin
		#(timeout_cycles * period);
		report_error("Timeout: the core did not finish its instruction count in time");
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected) else begin
			report_error($sformatf("[FAIL] %s: got %h, expected %h", name, got, expected));
		end
	endtask

	function automatic logic [31:0] reg_form_word(input logic [2:0] t, input logic [4:0] op,
		input logic [3:0] wc, input logic [3:0] ra, input logic [3:0] rb,
		input logic [11:0] aux);
		return {t, op, wc, ra, rb, aux};
	endfunction

	function automatic logic [31:0] imm_form_word(input logic [2:0] t, input logic [4:0] op,
		input logic [3:0] wc, input logic [3:0] ra, input logic [15:0] imm);
		return {t, op, wc, ra, imm};
	endfunction

	function automatic logic cond_holds(input logic [2:0] c);
		case (c)
			core_pkg::cond_always:   return 1'b1;
			core_pkg::cond_zero:     return m_z;
			core_pkg::cond_not_zero: return !m_z;
			core_pkg::cond_carry:    return m_c;
			core_pkg::cond_sign:     return m_s;
			core_pkg::cond_overflow: return m_o;
			core_pkg::cond_not_sign: return !m_s;
			default:                 return 1'b0;
		endcase
	endfunction

	// Result and all four model flags
	task automatic compute_alu(input logic [4:0] op, input logic [31:0] a,
		input logic [31:0] b, output logic [31:0] r);
		logic [32:0] wide;
		m_c = 1'b0;
		m_o = 1'b0;
		case (op)
			core_pkg::alu_add: begin
				wide = {a[31], a} + {b[31], b}; // Signed sum one bit wider
				r    = wide[31:0];
				m_c  = (r < a); // Unsigned wrap
				m_o  = (wide[32] != wide[31]);
			end
			core_pkg::alu_sub: begin
				wide = {a[31], a} - {b[31], b};
				r    = wide[31:0];
				m_c  = (a >= b); // No borrow
				m_o  = (wide[32] != wide[31]);
			end
			core_pkg::alu_and: r = a & b;
			core_pkg::alu_or:  r = a | b;
			core_pkg::alu_xor: r = a ^ b;
			core_pkg::alu_shl: r = a << b[4:0];
			core_pkg::alu_shr: r = a >> b[4:0];
			default:           r = b;
		endcase
		m_z = (r == 32'd0);
		m_s = r[31];
	endtask

	task automatic predict_commit(output logic en, output logic [3:0] rd,
		output logic [31:0] data);
		logic [31:0] w;
		logic [31:0] next_pc;
		logic [31:0] addr;
		logic [31:0] imm;
		w       = m_imem[m_pc[7:0]];
		imm     = {{16{w[15]}}, w[15:0]};
		next_pc = m_pc + 32'd1;
		en      = 1'b0;
		rd      = w[23:20];
		data    = 32'd0;
		case (w[31:29])
			core_pkg::type_alu_reg: begin
				compute_alu(w[28:24], m_regs[w[19:16]], m_regs[w[15:12]], data);
				en = 1'b1;
			end
			core_pkg::type_alu_imm: begin
				compute_alu(w[28:24], m_regs[w[19:16]], imm, data);
				en = 1'b1;
			end
			core_pkg::type_load: begin
				addr = m_regs[w[19:16]] + imm;
				data = m_dmem[addr[7:0]];
				en   = 1'b1;
			end
			core_pkg::type_store: begin
				addr = m_regs[w[19:16]];
				m_dmem[addr[7:0]] = m_regs[w[15:12]];
			end
			core_pkg::type_branch: begin
				if (cond_holds(w[14:12])) begin
					next_pc = {{20{w[11]}}, w[11:0]};
				end
			end
			core_pkg::type_jump_reg: begin
				if (cond_holds(w[22:20])) begin
					next_pc = m_regs[w[15:12]];
				end
			end
			default: begin
				en = 1'b0; // Types 6 and 7
			end
		endcase
		if (en) begin
			m_regs[rd] = data;
		end
		m_pc = next_pc;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		run   = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < 16; i++) begin
			m_regs[i] = 32'd0;
		end
		m_pc = 32'd0;
		m_z  = 1'b0;
		m_c  = 1'b0;
		m_s  = 1'b0;
		m_o  = 1'b0;
	endtask

	task automatic load_program(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			run       = 1'b0;
			load_en   = 1'b1;
			load_addr = i[7:0];
			load_data = prog[i];
			m_imem[i] = prog[i];
		end
		@(negedge clk);
		load_en = 1'b0;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		run = 1'b0;
		@(posedge clk);
		check_value("retire", {31'd0, retire}, 32'd0);
		check_value("wb_en", {31'd0, wb_en}, 32'd0);
	endtask

	task automatic run_cycle();
		logic        exp_en;
		logic [3:0]  exp_reg;
		logic [31:0] exp_data;
		logic [31:0] exp_pc;
		@(negedge clk);
		run = 1'b1;
		@(posedge clk);
		exp_pc = m_pc;
		predict_commit(exp_en, exp_reg, exp_data);
		check_value("retire", {31'd0, retire}, 32'd1);
		check_value("retire_pc", retire_pc, exp_pc);
		check_value("wb_en", {31'd0, wb_en}, {31'd0, exp_en});
		if (exp_en) begin
			check_value("wb_reg", {28'd0, wb_reg}, {28'd0, exp_reg});
			check_value("wb_data", wb_data, exp_data);
		end
		committed++;
	endtask

	// Writes a*0x1357 into every data memory word a
	task automatic build_fill_program();
		prog[0] = reg_form_word(core_pkg::type_store, 5'd0, 4'd0, 4'd1, 4'd2, 12'd0);
		prog[1] = imm_form_word(core_pkg::type_alu_imm, core_pkg::alu_add, 4'd2, 4'd2, 16'h1357);
		prog[2] = imm_form_word(core_pkg::type_alu_imm, core_pkg::alu_add, 4'd1, 4'd1, 16'd1);
		prog[3] = imm_form_word(core_pkg::type_alu_imm, core_pkg::alu_and, 4'd3, 4'd1, 16'h00ff);
		prog[4] = reg_form_word(core_pkg::type_branch, 5'd0, 4'd0, 4'd0,
			{1'b0, core_pkg::cond_not_zero}, 12'd0);
		prog[5] = reg_form_word(core_pkg::type_branch, 5'd0, 4'd0, 4'd0,
			{1'b0, core_pkg::cond_always}, 12'd5);
	endtask

	function automatic logic [4:0] random_op();
		if ($urandom_range(0, 8) == 0) begin
			return {2'($urandom_range(1, 3)), 3'($urandom_range(0, 7))};
		end
		return 5'($urandom_range(0, 7));
	endfunction

	task automatic build_program();
		int         i;
		int         kind;
		logic [3:0] wc;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [2:0] cond;
		i = 0;
		while (i < prog_words - 1) begin
			kind = $urandom_range(0, 6);
			wc   = 4'($urandom_range(0, 14)); // r15 only ever holds jump targets
			ra   = 4'($urandom_range(0, 15));
			rb   = 4'($urandom_range(0, 15));
			cond = 3'($urandom_range(0, 7));
			if ((kind == 3 || kind == 5) && i == prog_words - 2) begin
				kind = 1; // Pair would not fit
			end
			case (kind)
				0: prog[i] = reg_form_word(core_pkg::type_alu_reg, random_op(), wc, ra, rb,
					12'($urandom));
				1: prog[i] = imm_form_word(core_pkg::type_alu_imm, random_op(), wc, ra,
					16'($urandom));
				2: prog[i] = imm_form_word(core_pkg::type_load, 5'd0, wc, ra, 16'($urandom));
				3: begin
					prog[i] = reg_form_word(core_pkg::type_store, 5'd0, 4'd0, ra, rb, 12'd0);
					i++;
					prog[i] = imm_form_word(core_pkg::type_load, 5'd0, wc, ra, 16'd0);
				end
				4: prog[i] = reg_form_word(core_pkg::type_branch, 5'd0, 4'd0, 4'd0,
					{1'b0, cond}, 12'($urandom_range(0, 63)));
				5: begin
					prog[i] = imm_form_word(core_pkg::type_alu_imm, core_pkg::alu_pass_b, 4'd15,
						4'd0, 16'($urandom_range(0, 63)));
					i++;
					prog[i] = reg_form_word(core_pkg::type_jump_reg, 5'd0, {1'b0, cond}, 4'd0,
						4'd15, 12'd0);
				end
				default: prog[i] = {3'($urandom_range(6, 7)), 29'($urandom)};
			endcase
			i++;
		end
		// Last word wraps back to the start
		prog[prog_words - 1] = reg_form_word(core_pkg::type_branch, 5'd0, 4'd0, 4'd0,
			{1'b0, core_pkg::cond_always}, 12'd0);
	endtask

	initial begin
		int stall;
		void'($urandom(86));
		reset       = 1'b1;
		run         = 1'b0;
		load_en     = 1'b0;
		load_addr   = 8'd0;
		load_data   = 32'd0;
		committed   = 0;
		stalls_used = 0;

		apply_reset();
		repeat (2) idle_cycle();
		build_fill_program();
		load_program(fill_words);
		repeat (fill_instrs) run_cycle();

		// Memories keep their contents across this reset
		apply_reset();
		build_program();
		load_program(prog_words);
		committed = 0;
		while (committed < rand_instrs) begin
			stall = $urandom_range(1, 5);
			if ($urandom_range(0, 9) == 0 && stalls_used + stall <= stall_budget) begin
				repeat (stall) idle_cycle();
				stalls_used += stall;
			end else begin
				run_cycle();
			end
		end
		@(negedge clk);
		run = 1'b0;
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/control_decoder.sv
`default_nettype none

module control_decoder (
	input  wire core_pkg::instr_t instr,
	output logic [4:0]            alu_op,
	output logic                  se_sel,
	output logic                  use_imm,
	output logic                  mem_write,
	output logic [1:0]            wb_sel,
	output logic [1:0]            branch_kind
);

	always_comb begin
		// Defaults describe a no-op
		alu_op      = core_pkg::alu_add;
		se_sel      = core_pkg::se_imm16;
		use_imm     = 1'b0;
		mem_write   = 1'b0;
		wb_sel      = core_pkg::wb_sel_none;
		branch_kind = core_pkg::pc_sel_inc;

		case (instr.rform.itype)
			core_pkg::type_alu_reg: begin
				alu_op = instr.rform.op;
				wb_sel = core_pkg::wb_sel_alu;
			end
			core_pkg::type_alu_imm: begin
				alu_op  = instr.iform.op;
				use_imm = 1'b1;
				wb_sel  = core_pkg::wb_sel_alu;
			end
			core_pkg::type_load: begin
				use_imm = 1'b1; // Address is ra plus imm16
				wb_sel  = core_pkg::wb_sel_mem;
			end
			core_pkg::type_store: begin
				mem_write = 1'b1;
			end
			core_pkg::type_branch: begin
				se_sel      = core_pkg::se_imm12; // Target sits in aux
				branch_kind = core_pkg::pc_sel_imm;
			end
			core_pkg::type_jump_reg: begin
				branch_kind = core_pkg::pc_sel_reg;
			end
			default: begin
				// Types 6 and 7 keep the no-op defaults
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int data_width     = 32;
	localparam int reg_addr_width = 4;
	localparam int mem_addr_width = 8;
	localparam int mem_words      = 256;

	// Types 6 and 7 are no-ops
	localparam logic [2:0] type_alu_reg  = 3'd0;
	localparam logic [2:0] type_alu_imm  = 3'd1;
	localparam logic [2:0] type_load     = 3'd2;
	localparam logic [2:0] type_store    = 3'd3;
	localparam logic [2:0] type_branch   = 3'd4;
	localparam logic [2:0] type_jump_reg = 3'd5;

	localparam logic [4:0] alu_add    = 5'd0;
	localparam logic [4:0] alu_sub    = 5'd1;
	localparam logic [4:0] alu_and    = 5'd2;
	localparam logic [4:0] alu_or     = 5'd3;
	localparam logic [4:0] alu_xor    = 5'd4;
	localparam logic [4:0] alu_shl    = 5'd5;
	localparam logic [4:0] alu_shr    = 5'd6;
	localparam logic [4:0] alu_pass_b = 5'd7;

	localparam logic se_imm16 = 1'b0;
	localparam logic se_imm12 = 1'b1;

	localparam logic [2:0] cond_always   = 3'd0;
	localparam logic [2:0] cond_zero     = 3'd1;
	localparam logic [2:0] cond_not_zero = 3'd2;
	localparam logic [2:0] cond_carry    = 3'd3;
	localparam logic [2:0] cond_sign     = 3'd4;
	localparam logic [2:0] cond_overflow = 3'd5;
	localparam logic [2:0] cond_not_sign = 3'd6;
	localparam logic [2:0] cond_never    = 3'd7;

	localparam logic [1:0] pc_sel_inc = 2'd0;
	localparam logic [1:0] pc_sel_imm = 2'd1;
	localparam logic [1:0] pc_sel_reg = 2'd2;

	localparam logic [1:0] wb_sel_alu  = 2'd0;
	localparam logic [1:0] wb_sel_mem  = 2'd1;
	localparam logic [1:0] wb_sel_none = 2'd2;

	// Bit positions in the flag word
	localparam int flag_o = 0;
	localparam int flag_s = 1;
	localparam int flag_c = 2;
	localparam int flag_z = 3;

	typedef struct packed {
		logic [2:0]                itype;
		logic [4:0]                op;
		logic [reg_addr_width-1:0] wc;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rb; // Low 3 bits are the branch condition
		logic [11:0]               aux;
	} reg_form_t;

	typedef struct packed {
		logic [2:0]                itype;
		logic [4:0]                op;
		logic [reg_addr_width-1:0] wc;
		logic [reg_addr_width-1:0] ra;
		logic [15:0]               imm;
	} imm_form_t;

	typedef union packed {
		reg_form_t rform;
		imm_form_t iform;
	} instr_t;

endpackage

`default_nettype wire

//--- rtl/core_top.sv
`default_nettype none

module core_top (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 run,
	input  wire                                 load_en,
	input  wire  [core_pkg::mem_addr_width-1:0] load_addr,
	input  wire  [core_pkg::data_width-1:0]     load_data,
	output logic                                retire,
	output logic [core_pkg::data_width-1:0]     retire_pc,
	output logic                                wb_en,
	output logic [core_pkg::reg_addr_width-1:0] wb_reg,
	output logic [core_pkg::data_width-1:0]     wb_data
);

	logic [core_pkg::data_width-1:0]     op_a;
	logic [core_pkg::data_width-1:0]     op_b;
	logic [core_pkg::data_width-1:0]     store_data;
	logic [4:0]                          alu_op;
	logic                                mem_write;
	logic [1:0]                          wb_sel;
	logic [core_pkg::reg_addr_width-1:0] dec_wb_reg; // Destination as decoded
	logic [3:0]                          flags;

	fetch_decode u_fetch (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.load_en    (load_en),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.flags      (flags),
		.wb_en      (wb_en),
		.wb_reg_in  (wb_reg),
		.wb_data    (wb_data),
		.pc         (retire_pc),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data),
		.alu_op     (alu_op),
		.mem_write  (mem_write),
		.wb_sel     (wb_sel),
		.wb_reg     (dec_wb_reg)
	);

	execute_stage u_exec (
		.clk        (clk),
		.reset      (reset),
		.run        (run),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data),
		.alu_op     (alu_op),
		.mem_write  (mem_write),
		.wb_sel     (wb_sel),
		.wb_reg     (dec_wb_reg),
		.flags      (flags),
		.wb_en      (wb_en),
		.wb_reg_out (wb_reg),
		.wb_data    (wb_data)
	);

	assign retire = run; // Every running cycle commits one instruction

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`default_nettype none

module execute_stage (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 run,
	input  wire  [core_pkg::data_width-1:0]     op_a,
	input  wire  [core_pkg::data_width-1:0]     op_b,
	input  wire  [core_pkg::data_width-1:0]     store_data,
	input  wire  [4:0]                          alu_op,
	input  wire                                 mem_write,
	input  wire  [1:0]                          wb_sel,
	input  wire  [core_pkg::reg_addr_width-1:0] wb_reg,
	output logic [3:0]                          flags,
	output logic                                wb_en,
	output logic [core_pkg::reg_addr_width-1:0] wb_reg_out,
	output logic [core_pkg::data_width-1:0]     wb_data
);

	logic [core_pkg::data_width:0]       sum;
	logic [core_pkg::data_width:0]       diff;
	logic [core_pkg::data_width-1:0]     result;
	logic [3:0]                          flags_next;
	logic [core_pkg::mem_addr_width-1:0] dm_addr;
	logic [core_pkg::data_width-1:0]     dmem [core_pkg::mem_words];

	assign sum  = {1'b0, op_a} + {1'b0, op_b};
	assign diff = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1; // Top bit is no-borrow

	always_comb begin
		flags_next = '0;
		case (alu_op)
			core_pkg::alu_add: begin
				result                       = sum[core_pkg::data_width-1:0];
				flags_next[core_pkg::flag_c] = sum[core_pkg::data_width];
				flags_next[core_pkg::flag_o] = (op_a[31] == op_b[31]) && (result[31] != op_a[31]);
			end
			core_pkg::alu_sub: begin
				result                       = diff[core_pkg::data_width-1:0];
				flags_next[core_pkg::flag_c] = diff[core_pkg::data_width];
				flags_next[core_pkg::flag_o] = (op_a[31] != op_b[31]) && (result[31] != op_a[31]);
			end
			core_pkg::alu_and: result = op_a & op_b;
			core_pkg::alu_or:  result = op_a | op_b;
			core_pkg::alu_xor: result = op_a ^ op_b;
			core_pkg::alu_shl: result = op_a << op_b[4:0];
			core_pkg::alu_shr: result = op_a >> op_b[4:0];
			default:           result = op_b; // Pass_b and any op with upper bits set
		endcase
		flags_next[core_pkg::flag_z] = (result == '0);
		flags_next[core_pkg::flag_s] = result[31];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (run && wb_sel == core_pkg::wb_sel_alu) begin
			flags <= flags_next;
		end
	end

	// Stores address with ra alone, loads with ra plus offset
	assign dm_addr = mem_write ? op_a[core_pkg::mem_addr_width-1:0]
	                           : result[core_pkg::mem_addr_width-1:0];

	always_ff @(posedge clk) begin
		if (run && mem_write) begin
			dmem[dm_addr] <= store_data;
		end
	end

	assign wb_data    = (wb_sel == core_pkg::wb_sel_mem) ? dmem[dm_addr] : result;
	assign wb_en      = run && (wb_sel != core_pkg::wb_sel_none);
	assign wb_reg_out = wb_reg;

endmodule

`default_nettype wire

//--- rtl/fetch_decode.sv
`default_nettype none

module fetch_decode (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 run,
	input  wire                                 load_en,
	input  wire  [core_pkg::mem_addr_width-1:0] load_addr,
	input  wire  [core_pkg::data_width-1:0]     load_data,
	input  wire  [3:0]                          flags,
	input  wire                                 wb_en,
	input  wire  [core_pkg::reg_addr_width-1:0] wb_reg_in,
	input  wire  [core_pkg::data_width-1:0]     wb_data,
	output logic [core_pkg::data_width-1:0]     pc,
	output logic [core_pkg::data_width-1:0]     op_a,
	output logic [core_pkg::data_width-1:0]     op_b,
	output logic [core_pkg::data_width-1:0]     store_data,
	output logic [4:0]                          alu_op,
	output logic                                mem_write,
	output logic [1:0]                          wb_sel,
	output logic [core_pkg::reg_addr_width-1:0] wb_reg
);

	core_pkg::instr_t                instr;
	logic [core_pkg::data_width-1:0] rd_b;
	logic [core_pkg::data_width-1:0] ext;
	logic [core_pkg::data_width-1:0] pc_next;
	logic                            se_sel;
	logic                            use_imm;
	logic [1:0]                      branch_kind;
	logic [1:0]                      pc_sel;
	logic [2:0]                      cond;

	instruction_memory u_imem (
		.clk       (clk),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.addr      (pc[core_pkg::mem_addr_width-1:0]),
		.instr     (instr)
	);

	register_bank u_regs (
		.clk     (clk),
		.reset   (reset),
		.ra      (instr.rform.ra),
		.rb      (instr.rform.rb),
		.wr_en   (wb_en),
		.wr_reg  (wb_reg_in),
		.wr_data (wb_data),
		.rd_a    (op_a),
		.rd_b    (rd_b)
	);

	control_decoder u_dec (
		.instr       (instr),
		.alu_op      (alu_op),
		.se_sel      (se_sel),
		.use_imm     (use_imm),
		.mem_write   (mem_write),
		.wb_sel      (wb_sel),
		.branch_kind (branch_kind)
	);

	// Jump_reg keeps its condition in wc, branch in rb
	assign cond = (branch_kind == core_pkg::pc_sel_reg) ? instr.rform.wc[2:0]
	                                                   : instr.rform.rb[2:0];

	flag_tester u_tester (
		.flags       (flags),
		.cond        (cond),
		.branch_kind (branch_kind),
		.pc_sel      (pc_sel)
	);

	assign ext = (se_sel == core_pkg::se_imm12)
		? {{(core_pkg::data_width-12){instr.rform.aux[11]}}, instr.rform.aux}
		: {{(core_pkg::data_width-16){instr.iform.imm[15]}}, instr.iform.imm};

	assign op_b       = use_imm ? ext : rd_b;
	assign store_data = rd_b;
	assign wb_reg     = instr.rform.wc;

	always_comb begin
		case (pc_sel)
			core_pkg::pc_sel_imm: pc_next = ext;
			core_pkg::pc_sel_reg: pc_next = rd_b;
			default:              pc_next = pc + 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (run) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

//--- rtl/flag_tester.sv
`default_nettype none

module flag_tester (
	input  wire  [3:0] flags,
	input  wire  [2:0] cond,
	input  wire  [1:0] branch_kind,
	output logic [1:0] pc_sel
);

	logic taken;

	always_comb begin
		case (cond)
			core_pkg::cond_always:   taken = 1'b1;
			core_pkg::cond_zero:     taken = flags[core_pkg::flag_z];
			core_pkg::cond_not_zero: taken = !flags[core_pkg::flag_z];
			core_pkg::cond_carry:    taken = flags[core_pkg::flag_c];
			core_pkg::cond_sign:     taken = flags[core_pkg::flag_s];
			core_pkg::cond_overflow: taken = flags[core_pkg::flag_o];
			core_pkg::cond_not_sign: taken = !flags[core_pkg::flag_s];
			default:                 taken = 1'b0; // cond_never
		endcase
	end

	// Non-branch instructions carry pc_sel_inc as their kind
	assign pc_sel = taken ? branch_kind : core_pkg::pc_sel_inc;

endmodule

`default_nettype wire

//--- rtl/instruction_memory.sv
`default_nettype none

module instruction_memory (
	input  wire                                 clk,
	input  wire                                 load_en,
	input  wire  [core_pkg::mem_addr_width-1:0] load_addr,
	input  wire  [core_pkg::data_width-1:0]     load_data,
	input  wire  [core_pkg::mem_addr_width-1:0] addr,
	output core_pkg::instr_t                    instr
);

	logic [core_pkg::data_width-1:0] mem [core_pkg::mem_words];

	// One program word per load strobe
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	assign instr = mem[addr]; // Async fetch

endmodule

`default_nettype wire

//--- rtl/register_bank.sv
`default_nettype none

module register_bank (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [core_pkg::reg_addr_width-1:0] ra,
	input  wire  [core_pkg::reg_addr_width-1:0] rb,
	input  wire                                 wr_en,
	input  wire  [core_pkg::reg_addr_width-1:0] wr_reg,
	input  wire  [core_pkg::data_width-1:0]     wr_data,
	output logic [core_pkg::data_width-1:0]     rd_a,
	output logic [core_pkg::data_width-1:0]     rd_b
);

	logic [core_pkg::data_width-1:0] regs [2**core_pkg::reg_addr_width];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**core_pkg::reg_addr_width; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// Reads see the old value until the edge
	assign rd_a = regs[ra];
	assign rd_b = regs[rb];

endmodule

`default_nettype wire

//--- verilog.f
rtl/core_pkg.sv
rtl/instruction_memory.sv
rtl/register_bank.sv
rtl/control_decoder.sv
rtl/flag_tester.sv
rtl/fetch_decode.sv
rtl/execute_stage.sv
rtl/core_top.sv
dv/core_tb.sv
